/* logic/mont_pkg.sv */
//////////////////////////////
// default widths and pipeline latencies
// of the montgomery multiplier
//////////////////////////////

package mont_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    // limb width of the default build
    localparam int DEF_LIMB_W = 22;
    // operand width, at most three limbs minus two bits
    localparam int DEF_IN_W   = 64;
    // the 3-way karatsuba form fixes this
    localparam int NUM_LIMBS  = 3;

    //////////////////////////////
    // latencies in clock cycles
    //////////////////////////////
    // limb multiplier
    localparam int MUL_LAT    = 3;
    // limb pre-add registers in front of the multipliers
    localparam int PREADD_LAT = 1;
    // pre-add, multiply, recombine
    localparam int KARA_LAT   = PREADD_LAT + MUL_LAT + 1;
    // multiply, then the mod R output register
    localparam int Q_LAT      = MUL_LAT + 1;
    // product, quotient, reduction with its add-and-shift register
    localparam int TOTAL_LAT  = KARA_LAT + Q_LAT + KARA_LAT + 1;

endpackage

/* logic/delay_line.sv */
//////////////////////////////
// register chain for stage alignment
//////////////////////////////

`timescale 1ns/1ns

module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 8
) (
    input  logic             i_clk,
    input  logic             i_rstn,
    input  logic [WIDTH-1:0] i_d,
    output logic [WIDTH-1:0] o_q
);

    // tap 0 is the first register after the input
    logic [WIDTH-1:0] tap_q [DEPTH];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int k = 0; k < DEPTH; k++) begin
                tap_q[k] <= '0;
            end
        end else begin
            tap_q[0] <= i_d;
            for (int k = 1; k < DEPTH; k++) begin
                tap_q[k] <= tap_q[k-1];
            end
        end
    end

    assign o_q = tap_q[DEPTH-1];

endmodule

/* logic/limb_mul_pipe.sv */
//////////////////////////////
// three-cycle limb multiplier
//////////////////////////////

`timescale 1ns/1ns

module limb_mul_pipe import mont_pkg::*; #(
    parameter int LIMB_W = DEF_LIMB_W
) (
    input  logic                  i_clk,
    input  logic                  i_rstn,
    input  logic [LIMB_W+1:0]     i_x,
    input  logic [LIMB_W+1:0]     i_y,
    output logic [2*LIMB_W+3:0]   o_p
);

    // widened limb, room for a pairwise limb sum
    localparam int OPW  = LIMB_W + 2;
    // y is cut into a low and a high chunk
    localparam int LO_W = OPW / 2;
    localparam int HI_W = OPW - LO_W;

    logic [OPW-1:0]      x_q;
    logic [OPW-1:0]      y_q;
    logic [OPW+LO_W-1:0] pp_lo_q;
    logic [OPW+HI_W-1:0] pp_hi_q;

    // cycle 1: operand registers
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            x_q <= '0;
            y_q <= '0;
        end else begin
            x_q <= i_x;
            y_q <= i_y;
        end
    end

    // cycle 2: partial products of each chunk
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            pp_lo_q <= '0;
            pp_hi_q <= '0;
        end else begin
            pp_lo_q <= {{LO_W{1'b0}}, x_q} * {{OPW{1'b0}}, y_q[LO_W-1:0]};
            pp_hi_q <= {{HI_W{1'b0}}, x_q} * {{OPW{1'b0}}, y_q[OPW-1:LO_W]};
        end
    end

    // cycle 3: shifted sum, both sides are exactly 2*OPW wide
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_p <= '0;
        end else begin
            o_p <= {pp_hi_q, {LO_W{1'b0}}} + {{HI_W{1'b0}}, pp_lo_q};
        end
    end

endmodule

/* logic/karatsuba3_mul.sv */
//////////////////////////////
// 3-way karatsuba product of two
// three-limb operands
//////////////////////////////

`timescale 1ns/1ns

module karatsuba3_mul import mont_pkg::*; #(
    parameter int LIMB_W = DEF_LIMB_W
) (
    input  logic                            i_clk,
    input  logic                            i_rstn,
    input  logic [NUM_LIMBS*LIMB_W-1:0]     i_x,
    input  logic [NUM_LIMBS*LIMB_W-1:0]     i_y,
    output logic [2*NUM_LIMBS*LIMB_W-1:0]   o_p
);

    localparam int OPW   = LIMB_W + 2;
    localparam int MP_W  = 2 * OPW;
    localparam int P_W   = 2 * NUM_LIMBS * LIMB_W;
    // slots 0..2 are the diagonals, 3..5 the sums of limbs 0+1, 0+2, 1+2
    localparam int N_MUL = 6;

    logic [OPW-1:0]  xl [NUM_LIMBS];
    logic [OPW-1:0]  yl [NUM_LIMBS];
    logic [OPW-1:0]  op_x_q [N_MUL];
    logic [OPW-1:0]  op_y_q [N_MUL];
    logic [MP_W-1:0] prod [N_MUL];
    logic [P_W-1:0]  ext [N_MUL];
    logic [P_W-1:0]  mid01;
    logic [P_W-1:0]  mid02;
    logic [P_W-1:0]  mid12;
    logic [P_W-1:0]  sum_c;

    // limb split, two spare bits on top
    always_comb begin
        for (int k = 0; k < NUM_LIMBS; k++) begin
            xl[k] = {2'b00, i_x[k*LIMB_W +: LIMB_W]};
            yl[k] = {2'b00, i_y[k*LIMB_W +: LIMB_W]};
        end
    end

    //////////////////////////////
    // pre-add stage
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int k = 0; k < N_MUL; k++) begin
                op_x_q[k] <= '0;
                op_y_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_LIMBS; k++) begin
                op_x_q[k] <= xl[k];
                op_y_q[k] <= yl[k];
            end
            op_x_q[3] <= xl[0] + xl[1];
            op_y_q[3] <= yl[0] + yl[1];
            op_x_q[4] <= xl[0] + xl[2];
            op_y_q[4] <= yl[0] + yl[2];
            op_x_q[5] <= xl[1] + xl[2];
            op_y_q[5] <= yl[1] + yl[2];
        end
    end

    for (genvar g = 0; g < N_MUL; g++) begin : g_mul
        limb_mul_pipe #(
            .LIMB_W (LIMB_W)
        ) u_limb_mul (
            .i_clk  (i_clk),
            .i_rstn (i_rstn),
            .i_x    (op_x_q[g]),
            .i_y    (op_y_q[g]),
            .o_p    (prod[g])
        );
    end

    //////////////////////////////
    // recombination
    //////////////////////////////
    always_comb begin
        for (int k = 0; k < N_MUL; k++) begin
            ext[k] = {{(P_W-MP_W){1'b0}}, prod[k]};
        end
        // cross terms, the limb-2 position also carries x1*y1
        mid01 = ext[3] - ext[0] - ext[1];
        mid02 = ext[4] - ext[0] - ext[2] + ext[1];
        mid12 = ext[5] - ext[1] - ext[2];
        sum_c = ext[0]
              + (mid01  << LIMB_W)
              + (mid02  << (2*LIMB_W))
              + (mid12  << (3*LIMB_W))
              + (ext[2] << (4*LIMB_W));
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_p <= '0;
        end else begin
            o_p <= sum_c;
        end
    end

endmodule

/* logic/mont_q_stage.sv */
//////////////////////////////
// montgomery quotient, low half of t*m_inv
//////////////////////////////

`timescale 1ns/1ns

module mont_q_stage import mont_pkg::*; #(
    parameter int LIMB_W = DEF_LIMB_W
) (
    input  logic                          i_clk,
    input  logic                          i_rstn,
    input  logic [NUM_LIMBS*LIMB_W-1:0]   i_t_low,
    input  logic [NUM_LIMBS*LIMB_W-1:0]   i_m_inv,
    output logic [NUM_LIMBS*LIMB_W-1:0]   o_q
);

    localparam int OPW   = LIMB_W + 2;
    localparam int MP_W  = 2 * OPW;
    localparam int Q_W   = NUM_LIMBS * LIMB_W;
    localparam int N_MUL = 5;

    logic [OPW-1:0]  ul [NUM_LIMBS];
    logic [OPW-1:0]  ml [NUM_LIMBS];
    logic [OPW-1:0]  op_x [N_MUL];
    logic [OPW-1:0]  op_y [N_MUL];
    logic [MP_W-1:0] prod [N_MUL];
    logic [Q_W-1:0]  ext [N_MUL];
    logic [Q_W-1:0]  q_c;

    always_comb begin
        for (int k = 0; k < NUM_LIMBS; k++) begin
            ul[k] = {2'b00, i_t_low[k*LIMB_W +: LIMB_W]};
            ml[k] = {2'b00, i_m_inv[k*LIMB_W +: LIMB_W]};
        end
    end

    // only the products that land below R
    always_comb begin
        op_x[0] = ul[0];
        op_y[0] = ml[0];
        op_x[1] = ul[1];
        op_y[1] = ml[1];
        op_x[2] = ul[0];
        op_y[2] = ml[2];
        op_x[3] = ul[2];
        op_y[3] = ml[0];
        // karatsuba sum product for the limb-1 term, no pre-add register here
        op_x[4] = ul[0] + ul[1];
        op_y[4] = ml[0] + ml[1];
    end

    for (genvar g = 0; g < N_MUL; g++) begin : g_mul
        limb_mul_pipe #(
            .LIMB_W (LIMB_W)
        ) u_limb_mul (
            .i_clk  (i_clk),
            .i_rstn (i_rstn),
            .i_x    (op_x[g]),
            .i_y    (op_y[g]),
            .o_p    (prod[g])
        );
    end

    // sum wraps at Q_W bits, which is the mod R
    always_comb begin
        for (int k = 0; k < N_MUL; k++) begin
            ext[k] = {{(Q_W-MP_W){1'b0}}, prod[k]};
        end
        q_c = ext[0]
            + ((ext[4] - ext[0] - ext[1]) << LIMB_W)
            + ((ext[2] + ext[3] + ext[1]) << (2*LIMB_W));
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_q <= '0;
        end else begin
            o_q <= q_c;
        end
    end

endmodule

/* logic/mont_reduce_stage.sv */
//////////////////////////////
// reduction, (t + q*m) / R
//////////////////////////////

`timescale 1ns/1ns

module mont_reduce_stage import mont_pkg::*; #(
    parameter int LIMB_W = DEF_LIMB_W,
    parameter int IN_W   = DEF_IN_W
) (
    input  logic                            i_clk,
    input  logic                            i_rstn,
    input  logic [NUM_LIMBS*LIMB_W-1:0]     i_q,
    input  logic [IN_W-1:0]                 i_m,
    input  logic [2*NUM_LIMBS*LIMB_W-1:0]   i_t,
    output logic [IN_W:0]                   o_res
);

    localparam int OP_W = NUM_LIMBS * LIMB_W;
    localparam int P_W  = 2 * OP_W;

    logic [P_W-1:0] qm;
    logic [P_W-1:0] t_al;
    logic [P_W-1:0] sum_c;

    // full q*m, no truncation
    karatsuba3_mul #(
        .LIMB_W (LIMB_W)
    ) u_qm_mul (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_x    (i_q),
        .i_y    ({{(OP_W-IN_W){1'b0}}, i_m}),
        .o_p    (qm)
    );

    // t waits for the product
    delay_line #(
        .DEPTH  (KARA_LAT),
        .WIDTH  (P_W)
    ) u_t_dly (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_d    (i_t),
        .o_q    (t_al)
    );

    assign sum_c = t_al + qm;

    // low three limbs are zero by choice of q, result is below 2m
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_res <= '0;
        end else begin
            o_res <= sum_c[OP_W +: IN_W+1];
        end
    end

endmodule

/* logic/mont_mul_top.sv */
//////////////////////////////
// pipelined montgomery multiplier top
//////////////////////////////

`timescale 1ns/1ns

module mont_mul_top import mont_pkg::*; #(
    parameter int LIMB_W = DEF_LIMB_W,
    parameter int IN_W   = DEF_IN_W
) (
    input  logic                          i_clk,
    input  logic                          i_rstn,
    input  logic [IN_W-1:0]               i_a,
    input  logic [IN_W-1:0]               i_b,
    input  logic [IN_W-1:0]               i_m,
    input  logic [NUM_LIMBS*LIMB_W-1:0]   i_m_inv,
    output logic [IN_W:0]                 o_res
);

    localparam int OP_W = NUM_LIMBS * LIMB_W;
    localparam int P_W  = 2 * OP_W;

    // stage 1 product a*b
    logic [P_W-1:0]  t;
    logic [P_W-1:0]  t_al;
    logic [OP_W-1:0] m_inv_al;
    logic [OP_W-1:0] q;
    logic [IN_W-1:0] m_al;

    //////////////////////////////
    // stage 1, full product
    //////////////////////////////
    karatsuba3_mul #(
        .LIMB_W (LIMB_W)
    ) u_ab_mul (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_x    ({{(OP_W-IN_W){1'b0}}, i_a}),
        .i_y    ({{(OP_W-IN_W){1'b0}}, i_b}),
        .o_p    (t)
    );

    delay_line #(
        .DEPTH  (KARA_LAT),
        .WIDTH  (OP_W)
    ) u_m_inv_dly (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_d    (i_m_inv),
        .o_q    (m_inv_al)
    );

    //////////////////////////////
    // stage 2, quotient
    //////////////////////////////
    mont_q_stage #(
        .LIMB_W  (LIMB_W)
    ) u_q_stage (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_t_low (t[OP_W-1:0]),
        .i_m_inv (m_inv_al),
        .o_q     (q)
    );

    // t and m catch up with q
    delay_line #(
        .DEPTH  (Q_LAT),
        .WIDTH  (P_W)
    ) u_t_dly (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_d    (t),
        .o_q    (t_al)
    );

    delay_line #(
        .DEPTH  (KARA_LAT + Q_LAT),
        .WIDTH  (IN_W)
    ) u_m_dly (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_d    (i_m),
        .o_q    (m_al)
    );

    //////////////////////////////
    // stage 3, reduction
    //////////////////////////////
    mont_reduce_stage #(
        .LIMB_W (LIMB_W),
        .IN_W   (IN_W)
    ) u_reduce_stage (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_q    (q),
        .i_m    (m_al),
        .i_t    (t_al),
        .o_res  (o_res)
    );

endmodule

/* tests/mont_mul_properties.sv */
//////////////////////////////
// concurrent checks on the multiplier output
//////////////////////////////

`timescale 1ns/1ns

module mont_mul_properties import mont_pkg::*; #(
    parameter int IN_W = DEF_IN_W
) (
    input logic            i_clk,
    input logic            i_rstn,
    input logic [IN_W-1:0] i_m,
    input logic [IN_W:0]   i_res
);

    // saturates once the pipeline holds only sets taken after reset
    int unsigned since_rst;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            since_rst <= 0;
        end else if (since_rst <= TOTAL_LAT) begin
            since_rst <= since_rst + 1;
        end
    end

    a_zero_in_reset: assert property (@(posedge i_clk) !i_rstn |-> i_res == '0)
        else $error("result is not zero while reset is low");

    a_no_unknown: assert property (@(posedge i_clk) disable iff (!i_rstn) !$isunknown(i_res))
        else $error("result has unknown bits");

    // the result is seen one edge after its register loads, TOTAL_LAT edges after its modulus
    a_below_2m: assert property (@(posedge i_clk) disable iff (!i_rstn)
        since_rst > TOTAL_LAT |-> i_res < {$past(i_m, TOTAL_LAT), 1'b0})
        else $error("result is not below twice its modulus");

endmodule

bind mont_mul_top mont_mul_properties #(
    .IN_W   (IN_W)
) u_props (
    .i_clk  (i_clk),
    .i_rstn (i_rstn),
    .i_m    (i_m),
    .i_res  (o_res)
);

/* tests/tb_mont_mul.sv */
//////////////////////////////
// testbench for the pipelined montgomery
// multiplier with its reference model
//////////////////////////////

`timescale 1ns/1ns

module tb_mont_mul import mont_pkg::*; ();

    localparam int IN_W         = DEF_IN_W;
    localparam int OP_W         = NUM_LIMBS * DEF_LIMB_W;
    // wide enough for t + q*m without wrapping
    localparam int WIDE         = 2 * OP_W + 2;
    localparam int RESET_CYCLES = 16;
    localparam logic [31:0] LFSR_SEED = 32'd56;
    localparam logic [31:0] LFSR_TAPS = 32'hB4BC_D35C;
    // odd modulus with the top bit set, used while idle
    localparam logic [IN_W-1:0] IDLE_M = 64'hC000_0000_0000_0001;

    localparam int N_SMALL    = 3;
    localparam int N_STREAM   = 40;
    localparam int N_SWITCH   = 20;
    localparam int N_CHAIN    = 8;
    localparam int N_RESET    = 20;
    localparam int TEST_SETS  = N_SMALL + N_STREAM + N_SWITCH + N_CHAIN + 2 * N_RESET;
    localparam int MAX_CYCLES = TEST_SETS + TOTAL_LAT + 100;

    typedef struct packed {
        logic [IN_W:0]   res;
        logic [IN_W-1:0] m;
        logic [IN_W-1:0] x;
        logic            cong;
    } expect_t;

    logic              i_clk;
    logic              i_rstn;
    logic [IN_W-1:0]   i_a;
    logic [IN_W-1:0]   i_b;
    logic [IN_W-1:0]   i_m;
    logic [OP_W-1:0]   i_m_inv;
    logic [IN_W:0]     o_res;

    logic [31:0] lfsr_state;
    logic        rstn_level;
    int          cycle_cnt = 0;
    // one entry per driven cycle, each due TOTAL_LAT falling edges after its push
    expect_t     exp_q [$];

    mont_mul_top u_mont_mul_top (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_a     (i_a),
        .i_b     (i_b),
        .i_m     (i_m),
        .i_m_inv (i_m_inv),
        .o_res   (o_res)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            end_on_failure();
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // -m^-1 mod R by newton iteration, bits of precision double each round
    function automatic logic [OP_W-1:0] neg_inverse(input logic [IN_W-1:0] m);
        logic [OP_W-1:0] mm;
        logic [OP_W-1:0] inv;
        mm  = OP_W'(m);
        inv = mm;
        for (int k = 0; k < 5; k++) begin
            inv = inv * (OP_W'(2) - mm * inv);
        end
        return OP_W'(0) - inv;
    endfunction

    // res = (a*b + q*m) / R with q = ((a*b mod R) * m_inv) mod R
    function automatic logic [IN_W:0] mont_ref(input logic [IN_W-1:0] a,
                                               input logic [IN_W-1:0] b,
                                               input logic [IN_W-1:0] m,
                                               input logic [OP_W-1:0] minv);
        logic [WIDE-1:0] t;
        logic [WIDE-1:0] q;
        logic [WIDE-1:0] s;
        t = WIDE'(a) * WIDE'(b);
        q = WIDE'(t[OP_W-1:0]) * WIDE'(minv);
        q = WIDE'(q[OP_W-1:0]);
        s = t + q * WIDE'(m);
        return s[OP_W +: IN_W+1];
    endfunction

    function automatic logic [IN_W-1:0] to_mont(input logic [IN_W-1:0] x,
                                                input logic [IN_W-1:0] m);
        logic [WIDE-1:0] r;
        r = (WIDE'(x) << OP_W) % WIDE'(m);
        return r[IN_W-1:0];
    endfunction

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////
    task automatic end_on_failure();
        $display("Test FAILED");
        $fatal(1, "stopped on the first error");
    endtask

    task automatic rand_word(output logic [IN_W-1:0] v);
        v = '0;
        for (int k = 0; k < IN_W; k++) begin
            v = {v[IN_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic rand_below(input logic [IN_W-1:0] m, output logic [IN_W-1:0] v);
        rand_word(v);
        v = v % m;
    endtask

    task automatic rand_modulus(output logic [IN_W-1:0] m);
        rand_word(m);
        m[IN_W-1] = 1'b1;
        m[0]      = 1'b1;
    endtask

    // the pipeline holds zeros after reset, so every due result is zero
    task automatic refill_expected();
        exp_q.delete();
        repeat (TOTAL_LAT) exp_q.push_back('0);
    endtask

    task automatic check_entry(input expect_t e);
        assert (o_res === e.res) else begin
            $display("FAIL o_res: got %h expected %h", o_res, e.res);
            end_on_failure();
        end
        if (e.cong) begin
            assert ((o_res % {1'b0, e.m}) == {1'b0, e.x}) else begin
                $display("FAIL o_res mod m: got %h expected %h", o_res % {1'b0, e.m}, e.x);
                end_on_failure();
            end
        end
    endtask

    task automatic apply_set(input logic [IN_W-1:0] a, input logic [IN_W-1:0] b,
                             input logic [IN_W-1:0] m, input logic [OP_W-1:0] minv,
                             input logic [IN_W-1:0] x, input logic cong);
        expect_t e;
        @(negedge i_clk);
        if (exp_q.size() == TOTAL_LAT) begin
            check_entry(exp_q.pop_front());
        end
        i_rstn  = rstn_level;
        i_a     = a;
        i_b     = b;
        i_m     = m;
        i_m_inv = minv;
        e.res   = mont_ref(a, b, m, minv);
        e.m     = m;
        e.x     = x;
        e.cong  = cong;
        exp_q.push_back(e);
    endtask

    task automatic idle_cycle();
        apply_set('0, '0, IDLE_M, '0, '0, 1'b0);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic run_small_sets();
        logic [IN_W-1:0] m;
        logic [IN_W-1:0] r;
        logic [OP_W-1:0] minv;
        m    = 64'hF0E1_D2C3_B4A5_9687;
        minv = neg_inverse(m);
        rand_below(m, r);
        apply_set(IN_W'(1), IN_W'(1), m, minv, '0, 1'b0);
        apply_set('0, r, m, minv, '0, 1'b0);
        apply_set(m - IN_W'(2), m - IN_W'(1), m, minv, '0, 1'b0);
    endtask

    task automatic stream_one_modulus();
        logic [IN_W-1:0] m;
        logic [IN_W-1:0] a;
        logic [IN_W-1:0] b;
        logic [OP_W-1:0] minv;
        rand_modulus(m);
        minv = neg_inverse(m);
        for (int k = 0; k < N_STREAM; k++) begin
            rand_below(m, a);
            rand_below(m, b);
            apply_set(a, b, m, minv, '0, 1'b0);
        end
    endtask

    task automatic switch_modulus();
        logic [IN_W-1:0] m;
        logic [IN_W-1:0] a;
        logic [IN_W-1:0] b;
        for (int k = 0; k < N_SWITCH; k++) begin
            rand_modulus(m);
            rand_below(m, a);
            rand_below(m, b);
            apply_set(a, b, m, neg_inverse(m), '0, 1'b0);
        end
    endtask

    // x*R times 1 comes back as x modulo m
    task automatic chain_mont_form();
        logic [IN_W-1:0] m;
        logic [IN_W-1:0] x;
        logic [OP_W-1:0] minv;
        rand_modulus(m);
        minv = neg_inverse(m);
        for (int k = 0; k < N_CHAIN; k++) begin
            rand_below(m, x);
            apply_set(to_mont(x, m), IN_W'(1), m, minv, x, 1'b1);
        end
    endtask

    task automatic reset_mid_stream();
        logic [IN_W-1:0] m;
        logic [IN_W-1:0] a;
        logic [IN_W-1:0] b;
        logic [OP_W-1:0] minv;
        rand_modulus(m);
        minv = neg_inverse(m);
        for (int k = 0; k < 2 * N_RESET; k++) begin
            if (k == N_RESET) begin
                @(negedge i_clk);
                i_rstn = 1'b0;
                #1;
                assert (o_res == '0) else begin
                    $display("FAIL o_res: got %h expected %h", o_res, {(IN_W+1){1'b0}});
                    end_on_failure();
                end
                // zeros also cover the 15 cycles after release
                refill_expected();
                rstn_level = 1'b0;
                repeat (3) idle_cycle();
                rstn_level = 1'b1;
            end
            rand_below(m, a);
            rand_below(m, b);
            apply_set(a, b, m, minv, '0, 1'b0);
        end
    endtask

    initial begin
        i_rstn     = 1'b0;
        i_a        = '0;
        i_b        = '0;
        i_m        = IDLE_M;
        i_m_inv    = '0;
        lfsr_state = LFSR_SEED;
        rstn_level = 1'b0;
        refill_expected();
        repeat (RESET_CYCLES - 1) idle_cycle();
        rstn_level = 1'b1;

        run_small_sets();
        stream_one_modulus();
        switch_modulus();
        chain_mont_form();
        reset_mid_stream();

        // flush so every queued set is checked
        repeat (TOTAL_LAT) idle_cycle();
        $display("Test OK");
        $finish;
    end

endmodule

/* verilog.f */
logic/mont_pkg.sv
logic/delay_line.sv
logic/limb_mul_pipe.sv
logic/karatsuba3_mul.sv
logic/mont_q_stage.sv
logic/mont_reduce_stage.sv
logic/mont_mul_top.sv
tests/mont_mul_properties.sv
tests/tb_mont_mul.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the montgomery multiplier testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mont_mul -f verilog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mont_mul 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test OK" <<< "$out"; then
    exit 0
fi
exit 1
